//--- verilog/scaler_pkg.sv
package scaler_pkg;

  localparam int SIZE_W = 12;  // width of line and pixel counts
  localparam int FRAC_W = 17;  // fraction bits of the interpolation factor

  localparam logic [SIZE_W-1:0] LINES_NTSC  = SIZE_W'(240);
  localparam logic [SIZE_W-1:0] LINES_PAL   = SIZE_W'(288);
  localparam logic [SIZE_W-1:0] PIXELS_FULL = SIZE_W'(640);  // halved when nvideblur is clear

  localparam int AXIS_V = 0;
  localparam int AXIS_H = 1;

  // register map, 32-bit registers
  localparam logic [7:0] REG_CTRL    = 8'h00;  // bit0 palmode, bit1 nvideblur
  localparam logic [7:0] REG_VSIZE   = 8'h04;  // active lines 11:0, total lines 27:16
  localparam logic [7:0] REG_HSIZE   = 8'h08;  // same layout in pixels
  localparam logic [7:0] REG_STATUS  = 8'h0C;  // bit0 busy
  localparam logic [7:0] REG_VFACTOR = 8'h10;  // read only
  localparam logic [7:0] REG_HFACTOR = 8'h14;  // read only

  typedef struct packed {
    logic [SIZE_W-1:0] first;   // first input line or pixel to read
    logic [SIZE_W-1:0] needed;  // input lines or pixels used
    logic [SIZE_W-1:0] full;    // full input size
    logic [SIZE_W-1:0] total;   // total output size
    logic [FRAC_W:0]   factor;  // 2^FRAC_W / total
  } axis_result_t;

endpackage

//--- verilog/scaler_job_if.sv
`timescale 1ns/100ps

interface scaler_job_if;
  import scaler_pkg::*;

  logic              valid;       // one cycle start pulse
  logic              busy;
  logic [SIZE_W-1:0] in_full;
  logic [SIZE_W-1:0] active_out;
  logic [SIZE_W-1:0] total_out;

  modport src (
    output valid, in_full, active_out, total_out,
    input  busy
  );
  modport calc (
    input  valid, in_full, active_out, total_out,
    output busy
  );
endinterface

//--- verilog/scaler_result_if.sv
`timescale 1ns/100ps

interface scaler_result_if #(
  parameter int FRAC_W = scaler_pkg::FRAC_W
);
  import scaler_pkg::*;

  logic              done;    // one cycle pulse, fields valid from here on
  logic [SIZE_W-1:0] first;
  logic [SIZE_W-1:0] needed;
  logic [SIZE_W-1:0] full;
  logic [SIZE_W-1:0] total;
  logic [FRAC_W:0]   factor;

  modport calc (
    output done, first, needed, full, total, factor
  );
  modport commit (
    input  done, first, needed, full, total, factor
  );
endinterface

//--- verilog/scaler_axil_regs.sv
`timescale 1ns/100ps

module scaler_axil_regs #(
  parameter int ADDR_W = 8,
  parameter int FRAC_W = scaler_pkg::FRAC_W
) (
  input  logic              SYS_CLK,
  input  logic              arst_n_i,
  input  logic [ADDR_W-1:0] s_awaddr_i,
  input  logic              s_awvalid_i,
  output logic              s_awready_o,
  input  logic [31:0]       s_wdata_i,
  input  logic [3:0]        s_wstrb_i,
  input  logic              s_wvalid_i,
  output logic              s_wready_o,
  output logic [1:0]        s_bresp_o,
  output logic              s_bvalid_o,
  input  logic              s_bready_i,
  input  logic [ADDR_W-1:0] s_araddr_i,
  input  logic              s_arvalid_i,
  output logic              s_arready_o,
  output logic [31:0]       s_rdata_o,
  output logic [1:0]        s_rresp_o,
  output logic              s_rvalid_o,
  input  logic              s_rready_i,
  input  logic [FRAC_W:0]   v_factor_i,
  input  logic [FRAC_W:0]   h_factor_i,
  scaler_job_if.src         job_v,
  scaler_job_if.src         job_h
);
  import scaler_pkg::*;

  localparam logic [1:0]  RESP_OKAY   = 2'b00;
  localparam logic [1:0]  RESP_SLVERR = 2'b10;
  localparam logic [31:0] CTRL_MASK   = 32'h0000_0003;
  localparam logic [31:0] SIZE_MASK   = {{(16-SIZE_W){1'b0}}, {SIZE_W{1'b1}},
                                         {(16-SIZE_W){1'b0}}, {SIZE_W{1'b1}}};

  logic [ADDR_W-1:0] aw_addr_q;
  logic [31:0]       w_data_q;
  logic [3:0]        w_strb_q;
  logic              aw_done_q;
  logic              w_done_q;
  logic [31:0]       ctrl_q;
  logic [31:0]       vsize_q;
  logic [31:0]       hsize_q;
  logic              v_dirty_q;
  logic              h_dirty_q;
  logic              wr_fire;
  logic              wr_ctrl;
  logic              wr_vsize;
  logic              wr_hsize;
  logic              v_issue;
  logic              h_issue;
  logic              st_busy;
  logic [31:0]       rd_data;
  logic [1:0]        rd_resp;

  function automatic logic [31:0] wmerge(input logic [31:0] old_v, input logic [31:0] new_v,
                                         input logic [3:0] strb, input logic [31:0] mask);
    logic [31:0] merged;
    merged = old_v;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) merged[8*b +: 8] = new_v[8*b +: 8];
    end
    return merged & mask;
  endfunction

  assign wr_fire  = aw_done_q & w_done_q & ~s_bvalid_o;  // both channels accepted
  assign wr_ctrl  = wr_fire & (aw_addr_q == ADDR_W'(REG_CTRL));
  assign wr_vsize = wr_fire & (aw_addr_q == ADDR_W'(REG_VSIZE));
  assign wr_hsize = wr_fire & (aw_addr_q == ADDR_W'(REG_HSIZE));

  always_ff @(posedge SYS_CLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s_awready_o <= 1'b0;
      s_wready_o  <= 1'b0;
      aw_done_q   <= 1'b0;
      w_done_q    <= 1'b0;
      s_bvalid_o  <= 1'b0;
      s_bresp_o   <= RESP_OKAY;
    end else begin
      s_awready_o <= s_awvalid_i & ~s_awready_o & ~aw_done_q & ~s_bvalid_o;
      s_wready_o  <= s_wvalid_i & ~s_wready_o & ~w_done_q & ~s_bvalid_o;
      if (wr_fire) begin
        aw_done_q  <= 1'b0;
        w_done_q   <= 1'b0;
        s_bvalid_o <= 1'b1;
        s_bresp_o  <= (wr_ctrl | wr_vsize | wr_hsize) ? RESP_OKAY : RESP_SLVERR;
      end else begin
        if (s_awready_o & s_awvalid_i) aw_done_q <= 1'b1;
        if (s_wready_o & s_wvalid_i) w_done_q <= 1'b1;
        if (s_bvalid_o & s_bready_i) s_bvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge SYS_CLK) begin
    if (s_awready_o & s_awvalid_i) aw_addr_q <= s_awaddr_i;
    if (s_wready_o & s_wvalid_i) begin
      w_data_q <= s_wdata_i;
      w_strb_q <= s_wstrb_i;
    end
  end

  // a job leaves only while the calculator is idle, later writes just re-mark the axis
  assign v_issue = v_dirty_q & ~job_v.busy & ~job_v.valid;
  assign h_issue = h_dirty_q & ~job_h.busy & ~job_h.valid;

  always_ff @(posedge SYS_CLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_q      <= '0;
      vsize_q     <= '0;
      hsize_q     <= '0;
      v_dirty_q   <= 1'b0;
      h_dirty_q   <= 1'b0;
      job_v.valid <= 1'b0;
      job_h.valid <= 1'b0;
    end else begin
      if (wr_ctrl) ctrl_q <= wmerge(ctrl_q, w_data_q, w_strb_q, CTRL_MASK);
      if (wr_vsize) vsize_q <= wmerge(vsize_q, w_data_q, w_strb_q, SIZE_MASK);
      if (wr_hsize) hsize_q <= wmerge(hsize_q, w_data_q, w_strb_q, SIZE_MASK);
      v_dirty_q   <= (v_dirty_q & ~v_issue) | wr_ctrl | wr_vsize;  // new write wins
      h_dirty_q   <= (h_dirty_q & ~h_issue) | wr_ctrl | wr_hsize;
      job_v.valid <= v_issue;
      job_h.valid <= h_issue;
    end
  end

  assign job_v.in_full    = ctrl_q[0] ? LINES_PAL : LINES_NTSC;
  assign job_v.active_out = vsize_q[SIZE_W-1:0];
  assign job_v.total_out  = vsize_q[16 +: SIZE_W];
  assign job_h.in_full    = ctrl_q[1] ? PIXELS_FULL : (PIXELS_FULL >> 1);
  assign job_h.active_out = hsize_q[SIZE_W-1:0];
  assign job_h.total_out  = hsize_q[16 +: SIZE_W];

  assign st_busy = v_dirty_q | h_dirty_q | job_v.valid | job_h.valid | job_v.busy | job_h.busy;

  always_comb begin
    rd_data = '0;
    rd_resp = RESP_OKAY;
    case (s_araddr_i)
      ADDR_W'(REG_CTRL):    rd_data = ctrl_q;
      ADDR_W'(REG_VSIZE):   rd_data = vsize_q;
      ADDR_W'(REG_HSIZE):   rd_data = hsize_q;
      ADDR_W'(REG_STATUS):  rd_data = {31'd0, st_busy};
      ADDR_W'(REG_VFACTOR): rd_data = 32'(v_factor_i);
      ADDR_W'(REG_HFACTOR): rd_data = 32'(h_factor_i);
      default:              rd_resp = RESP_SLVERR;
    endcase
  end

  always_ff @(posedge SYS_CLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s_arready_o <= 1'b0;
      s_rvalid_o  <= 1'b0;
      s_rdata_o   <= '0;
      s_rresp_o   <= RESP_OKAY;
    end else begin
      s_arready_o <= s_arvalid_i & ~s_arready_o & ~s_rvalid_o;
      if (s_arready_o & s_arvalid_i) begin
        s_rvalid_o <= 1'b1;
        s_rdata_o  <= rd_data;
        s_rresp_o  <= rd_resp;
      end else if (s_rvalid_o & s_rready_i) begin
        s_rvalid_o <= 1'b0;
      end
    end
  end

endmodule

//--- verilog/serial_divide.sv
`timescale 1ns/100ps

module serial_divide #(
  parameter int FRAC_W = scaler_pkg::FRAC_W
) (
  input  logic                          SYS_CLK,
  input  logic                          arst_n_i,
  input  logic                          start_i,
  input  logic [scaler_pkg::SIZE_W-1:0] divisor_i,
  output logic [FRAC_W:0]               quotient_o,
  output logic                          done_o
);
  import scaler_pkg::*;

  localparam int CNT_W = $clog2(FRAC_W + 1);

  logic [SIZE_W-1:0] rem_q;
  logic [SIZE_W:0]   rem_sh;
  logic [SIZE_W:0]   rem_sub;
  logic              q_bit;
  logic [CNT_W-1:0]  cnt_q;  // quotient bits still to go
  logic              run_q;

  // dividend is a lone one at bit FRAC_W, so only the first step shifts in a one
  assign rem_sh  = start_i ? {{SIZE_W{1'b0}}, 1'b1} : {rem_q, 1'b0};
  assign rem_sub = rem_sh - {1'b0, divisor_i};
  assign q_bit   = (rem_sh >= {1'b0, divisor_i});  // always set for a zero divisor

  always_ff @(posedge SYS_CLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      run_q  <= 1'b0;
      cnt_q  <= '0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        run_q <= 1'b1;
        cnt_q <= CNT_W'(FRAC_W);
      end else if (run_q) begin
        cnt_q <= cnt_q - 1'b1;
        if (cnt_q == CNT_W'(1)) begin  // last bit
          run_q  <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge SYS_CLK) begin
    if (start_i | run_q) begin
      rem_q      <= q_bit ? rem_sub[SIZE_W-1:0] : rem_sh[SIZE_W-1:0];
      quotient_o <= {quotient_o[FRAC_W-1:0], q_bit};  // msb first
    end
  end

endmodule

//--- verilog/scaler_axis_calc.sv
`timescale 1ns/100ps

module scaler_axis_calc #(
  parameter int FRAC_W = scaler_pkg::FRAC_W
) (
  input  logic          SYS_CLK,
  input  logic          arst_n_i,
  scaler_job_if.calc    job,
  scaler_result_if.calc res
);
  import scaler_pkg::*;

  localparam int PROD_W = FRAC_W + 1 + 2 * SIZE_W;  // factor * full * active
  localparam int RES_W  = PROD_W - FRAC_W;

  logic [SIZE_W-1:0] in_full_q;
  logic [SIZE_W-1:0] active_q;
  logic [SIZE_W-1:0] total_q;
  logic              start_q;
  logic              busy_q;
  logic              div_done;
  logic [FRAC_W:0]   factor;
  logic              mul_vld_q;
  logic              rnd_vld_q;
  logic              done_q;
  logic [PROD_W-1:0] prod_q;
  logic [PROD_W-1:0] prod_rnd;
  logic [RES_W-1:0]  resmax_q;
  logic [SIZE_W-1:0] needed_c;
  logic [SIZE_W-1:0] needed_q;
  logic [SIZE_W-1:0] first_q;

  serial_divide #(
    .FRAC_W (FRAC_W)
  ) i_div (
    .SYS_CLK    (SYS_CLK),
    .arst_n_i   (arst_n_i),
    .start_i    (start_q),
    .divisor_i  (total_q),
    .quotient_o (factor),
    .done_o     (div_done)
  );

  always_ff @(posedge SYS_CLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      start_q   <= 1'b0;
      busy_q    <= 1'b0;
      mul_vld_q <= 1'b0;
      rnd_vld_q <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      start_q   <= job.valid;  // divider starts once the sizes are latched
      mul_vld_q <= div_done;
      rnd_vld_q <= mul_vld_q;
      done_q    <= rnd_vld_q;
      if (job.valid) begin
        busy_q <= 1'b1;
      end else if (rnd_vld_q) begin
        busy_q <= 1'b0;  // drops together with done
      end
    end
  end

  assign prod_rnd = prod_q + (PROD_W'(1) << (FRAC_W - 1));  // round half up
  assign needed_c = (resmax_q < RES_W'(in_full_q)) ? resmax_q[SIZE_W-1:0] : in_full_q;

  always_ff @(posedge SYS_CLK) begin
    if (job.valid) begin
      in_full_q <= job.in_full;
      active_q  <= job.active_out;
      total_q   <= job.total_out;
    end
    if (div_done) prod_q <= factor * in_full_q * active_q;
    if (mul_vld_q) resmax_q <= prod_rnd[PROD_W-1:FRAC_W];
    if (rnd_vld_q) begin
      needed_q <= needed_c;
      first_q  <= (in_full_q - needed_c) >> 1;  // keep the window centred
    end
  end

  assign job.busy   = busy_q;
  assign res.done   = done_q;
  assign res.first  = first_q;
  assign res.needed = needed_q;
  assign res.full   = in_full_q;
  assign res.total  = total_q;
  assign res.factor = factor;  // divider holds it until the next start

endmodule

//--- verilog/scaler_cfg_commit.sv
`timescale 1ns/100ps

module scaler_cfg_commit (
  input  logic                     SYS_CLK,
  input  logic                     arst_n_i,
  scaler_result_if.commit          res_v,
  scaler_result_if.commit          res_h,
  input  logic [1:0]               calc_busy_i,
  output scaler_pkg::axis_result_t v_cfg_o,
  output scaler_pkg::axis_result_t h_cfg_o,
  output logic                     cfg_update_o
);
  import scaler_pkg::*;

  axis_result_t hold_v_q;
  axis_result_t hold_h_q;
  logic [1:0]   pend_q;  // result waiting per axis
  logic [1:0]   seen_q;  // axis started a job since the last commit
  logic [1:0]   done_in;
  logic         commit;

  assign done_in[AXIS_V] = res_v.done;
  assign done_in[AXIS_H] = res_h.done;

  // every started axis has a result, nothing is running and nothing lands this cycle
  assign commit = (|pend_q) & ((pend_q | ~seen_q) == 2'b11) & ~|calc_busy_i & ~|done_in;

  always_ff @(posedge SYS_CLK) begin
    if (res_v.done) hold_v_q <= {res_v.first, res_v.needed, res_v.full, res_v.total, res_v.factor};
    if (res_h.done) hold_h_q <= {res_h.first, res_h.needed, res_h.full, res_h.total, res_h.factor};
  end

  always_ff @(posedge SYS_CLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_q       <= '0;
      seen_q       <= '0;
      v_cfg_o      <= '0;
      h_cfg_o      <= '0;
      cfg_update_o <= 1'b0;
    end else begin
      cfg_update_o <= commit;
      pend_q       <= (pend_q & {2{~commit}}) | done_in;
      seen_q       <= (seen_q & {2{~commit}}) | calc_busy_i;
      if (commit & pend_q[AXIS_V]) v_cfg_o <= hold_v_q;
      if (commit & pend_q[AXIS_H]) h_cfg_o <= hold_h_q;
    end
  end

endmodule

//--- verilog/scaler_cfg_top.sv
`timescale 1ns/100ps

module scaler_cfg_top #(
  parameter int ADDR_W = 8,
  parameter int FRAC_W = scaler_pkg::FRAC_W
) (
  input  logic                          SYS_CLK,
  input  logic                          arst_n_i,
  input  logic [ADDR_W-1:0]             s_awaddr_i,
  input  logic                          s_awvalid_i,
  output logic                          s_awready_o,
  input  logic [31:0]                   s_wdata_i,
  input  logic [3:0]                    s_wstrb_i,
  input  logic                          s_wvalid_i,
  output logic                          s_wready_o,
  output logic [1:0]                    s_bresp_o,
  output logic                          s_bvalid_o,
  input  logic                          s_bready_i,
  input  logic [ADDR_W-1:0]             s_araddr_i,
  input  logic                          s_arvalid_i,
  output logic                          s_arready_o,
  output logic [31:0]                   s_rdata_o,
  output logic [1:0]                    s_rresp_o,
  output logic                          s_rvalid_o,
  input  logic                          s_rready_i,
  output logic [scaler_pkg::SIZE_W-1:0] v_first_o,
  output logic [scaler_pkg::SIZE_W-1:0] v_needed_o,
  output logic [scaler_pkg::SIZE_W-1:0] v_full_o,
  output logic [scaler_pkg::SIZE_W-1:0] v_total_o,
  output logic [FRAC_W:0]               v_factor_o,
  output logic [scaler_pkg::SIZE_W-1:0] h_first_o,
  output logic [scaler_pkg::SIZE_W-1:0] h_needed_o,
  output logic [scaler_pkg::SIZE_W-1:0] h_full_o,
  output logic [scaler_pkg::SIZE_W-1:0] h_total_o,
  output logic [FRAC_W:0]               h_factor_o,
  output logic                          cfg_update_o
);
  import scaler_pkg::*;

  scaler_job_if                       job [2] ();
  scaler_result_if #(.FRAC_W(FRAC_W)) res [2] ();

  axis_result_t v_cfg;
  axis_result_t h_cfg;
  logic [1:0]   calc_busy;

  scaler_axil_regs #(
    .ADDR_W (ADDR_W),
    .FRAC_W (FRAC_W)
  ) i_regs (
    .*,
    .v_factor_i (v_cfg.factor),  // read back what the scaler sees
    .h_factor_i (h_cfg.factor),
    .job_v      (job[AXIS_V]),
    .job_h      (job[AXIS_H])
  );

  for (genvar i = 0; i < 2; i++) begin : g_axis  // 0 vertical, 1 horizontal
    scaler_axis_calc #(
      .FRAC_W (FRAC_W)
    ) i_calc (
      .SYS_CLK  (SYS_CLK),
      .arst_n_i (arst_n_i),
      .job      (job[i]),
      .res      (res[i])
    );
    assign calc_busy[i] = job[i].busy;
  end

  scaler_cfg_commit i_commit (
    .SYS_CLK      (SYS_CLK),
    .arst_n_i     (arst_n_i),
    .res_v        (res[AXIS_V]),
    .res_h        (res[AXIS_H]),
    .calc_busy_i  (calc_busy),
    .v_cfg_o      (v_cfg),
    .h_cfg_o      (h_cfg),
    .cfg_update_o (cfg_update_o)
  );

  assign v_first_o  = v_cfg.first;
  assign v_needed_o = v_cfg.needed;
  assign v_full_o   = v_cfg.full;
  assign v_total_o  = v_cfg.total;
  assign v_factor_o = v_cfg.factor;
  assign h_first_o  = h_cfg.first;
  assign h_needed_o = h_cfg.needed;
  assign h_full_o   = h_cfg.full;
  assign h_total_o  = h_cfg.total;
  assign h_factor_o = h_cfg.factor;

endmodule

//--- verification/scaler_cfg_tb.sv
`timescale 1ns/100ps

module scaler_cfg_tb;
  import scaler_pkg::*;

  localparam int AXI_TMO = 32;   // cycles per AXI channel
  localparam int UPD_TMO = 400;  // cycles for one cfg_update_o
  localparam int N_ENTRY = 5;
  localparam int SNAP_W  = 2 * $bits(axis_result_t);
  localparam logic [1:0] OKAY   = 2'b00;
  localparam logic [1:0] SLVERR = 2'b10;

  typedef struct packed {
    logic              pal;
    logic              blur;
    logic [SIZE_W-1:0] vact;
    logic [SIZE_W-1:0] vtot;
    logic [SIZE_W-1:0] hact;
    logic [SIZE_W-1:0] htot;
  } entry_t;

  logic              SYS_CLK;
  logic              arst_n_i;
  logic [7:0]        s_awaddr_i;
  logic              s_awvalid_i;
  logic              s_awready_o;
  logic [31:0]       s_wdata_i;
  logic [3:0]        s_wstrb_i;
  logic              s_wvalid_i;
  logic              s_wready_o;
  logic [1:0]        s_bresp_o;
  logic              s_bvalid_o;
  logic              s_bready_i;
  logic [7:0]        s_araddr_i;
  logic              s_arvalid_i;
  logic              s_arready_o;
  logic [31:0]       s_rdata_o;
  logic [1:0]        s_rresp_o;
  logic              s_rvalid_o;
  logic              s_rready_i;
  logic [SIZE_W-1:0] v_first_o;
  logic [SIZE_W-1:0] v_needed_o;
  logic [SIZE_W-1:0] v_full_o;
  logic [SIZE_W-1:0] v_total_o;
  logic [FRAC_W:0]   v_factor_o;
  logic [SIZE_W-1:0] h_first_o;
  logic [SIZE_W-1:0] h_needed_o;
  logic [SIZE_W-1:0] h_full_o;
  logic [SIZE_W-1:0] h_total_o;
  logic [FRAC_W:0]   h_factor_o;
  logic              cfg_update_o;

  int           errors;
  int           tests_run;
  int           tests_failed;
  int           upd_cnt = 0;
  bit           timed_out;
  entry_t       table_q [N_ENTRY];
  axis_result_t v_exp;
  axis_result_t h_exp;
  logic [31:0]  cur_ctrl;
  logic [31:0]  cur_vsize;
  logic [31:0]  cur_hsize;

  scaler_cfg_top i_dut (.*);

  always #4 SYS_CLK = ~SYS_CLK;  // 8 ns period

  always @(posedge SYS_CLK) begin
    if (cfg_update_o === 1'b1) upd_cnt <= upd_cnt + 1;  // update pulses so far
  end

  // factor = 2^FRAC_W / total, resmax = factor*full*active rounded, clamp and centre
  function automatic axis_result_t ref_axis(input int full, input int active, input int total);
    axis_result_t r;
    longint       fac;
    longint       resmax;
    longint       need;
    if (total == 0) fac = (longint'(1) << (FRAC_W + 1)) - 1;  // saturates
    else fac = (longint'(1) << FRAC_W) / total;
    resmax   = (fac * full * active + (longint'(1) << (FRAC_W - 1))) >> FRAC_W;
    need     = (resmax < full) ? resmax : full;
    r.first  = (full - need) / 2;
    r.needed = need;
    r.full   = full;
    r.total  = total;
    r.factor = fac;
    return r;
  endfunction

  function automatic logic [31:0] size_word(input int active, input int total);
    return {4'd0, total[SIZE_W-1:0], 4'd0, active[SIZE_W-1:0]};
  endfunction

  function automatic int lines_full(input logic pal);
    return pal ? 288 : 240;
  endfunction

  function automatic int pixels_full(input logic blur);
    return blur ? 640 : 320;
  endfunction

  function automatic logic [SNAP_W-1:0] outputs_now();
    return {v_first_o, v_needed_o, v_full_o, v_total_o, v_factor_o,
            h_first_o, h_needed_o, h_full_o, h_total_o, h_factor_o};
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic note_timeout(input string what);
    $display("Timeout: %s", what);
    timed_out = 1'b1;
    errors++;
  endtask

  task automatic report_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - err0);
    end
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int cnt;
    bit aw_take;
    bit w_take;
    resp = 2'bxx;
    if (!timed_out) begin
      s_awaddr_i  = addr;
      s_awvalid_i = 1'b1;
      s_wdata_i   = data;
      s_wstrb_i   = 4'hf;
      s_wvalid_i  = 1'b1;
      cnt = 0;
      while ((s_awvalid_i || s_wvalid_i) && cnt < AXI_TMO) begin
        aw_take = s_awvalid_i && s_awready_o;  // taken on the coming rising edge
        w_take  = s_wvalid_i && s_wready_o;
        @(negedge SYS_CLK);
        if (aw_take) s_awvalid_i = 1'b0;
        if (w_take) s_wvalid_i = 1'b0;
        cnt++;
      end
      if (s_awvalid_i || s_wvalid_i) note_timeout("write address or data never accepted");
      s_awvalid_i = 1'b0;
      s_wvalid_i  = 1'b0;
      s_bready_i  = 1'b1;
      cnt = 0;
      while (!timed_out && s_bvalid_o !== 1'b1) begin
        @(negedge SYS_CLK);
        cnt++;
        if (cnt >= AXI_TMO) note_timeout("no write response");
      end
      resp = s_bresp_o;
      @(negedge SYS_CLK);
      s_bready_i = 1'b0;
    end
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int cnt;
    bit ar_take;
    data = 'x;
    resp = 2'bxx;
    if (!timed_out) begin
      s_araddr_i  = addr;
      s_arvalid_i = 1'b1;
      cnt = 0;
      while (s_arvalid_i && cnt < AXI_TMO) begin
        ar_take = s_arready_o;
        @(negedge SYS_CLK);
        if (ar_take) s_arvalid_i = 1'b0;
        cnt++;
      end
      if (s_arvalid_i) note_timeout("read address never accepted");
      s_arvalid_i = 1'b0;
      s_rready_i  = 1'b1;
      cnt = 0;
      while (!timed_out && s_rvalid_o !== 1'b1) begin
        @(negedge SYS_CLK);
        cnt++;
        if (cnt >= AXI_TMO) note_timeout("no read data");
      end
      data = s_rdata_o;
      resp = s_rresp_o;
      @(negedge SYS_CLK);
      s_rready_i = 1'b0;
    end
  endtask

  task automatic write_expect(input logic [7:0] addr, input logic [31:0] data,
                              input logic [1:0] exp_resp, input string name);
    logic [1:0] resp;
    axi_write(addr, data, resp);
    compare_value({name, " bresp"}, resp, exp_resp);
  endtask

  task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp,
                             input string name);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(addr, data, resp);
    compare_value(name, data, exp);
    compare_value({name, " rresp"}, resp, OKAY);
  endtask

  task automatic wait_update();
    int cnt;
    cnt = 0;
    while (!timed_out && cfg_update_o !== 1'b1) begin
      @(negedge SYS_CLK);
      cnt++;
      if (cnt >= UPD_TMO) note_timeout("cfg_update_o never pulsed");
    end
  endtask

  // an update followed by an idle status read is the last one of a burst
  task automatic wait_settled();
    logic [31:0] st;
    logic [1:0]  resp;
    bit          idle;
    int          rounds;
    idle   = 1'b0;
    rounds = 0;
    while (!timed_out && !idle && rounds < 8) begin
      wait_update();
      axi_read(REG_STATUS, st, resp);
      idle = (st[0] === 1'b0);
      rounds++;
    end
    if (!timed_out && !idle) note_timeout("configuration still busy after 8 updates");
  endtask

  task automatic check_outputs(input axis_result_t v, input axis_result_t h);
    compare_value("v_first_o", v_first_o, v.first);
    compare_value("v_needed_o", v_needed_o, v.needed);
    compare_value("v_full_o", v_full_o, v.full);
    compare_value("v_total_o", v_total_o, v.total);
    compare_value("v_factor_o", v_factor_o, v.factor);
    compare_value("h_first_o", h_first_o, h.first);
    compare_value("h_needed_o", h_needed_o, h.needed);
    compare_value("h_full_o", h_full_o, h.full);
    compare_value("h_total_o", h_total_o, h.total);
    compare_value("h_factor_o", h_factor_o, h.factor);
  endtask

  task automatic check_reset_state();
    int err0;
    err0 = errors;
    check_outputs('0, '0);
    compare_value("cfg_update_o", cfg_update_o, 1'b0);
    read_expect(REG_STATUS, 32'd0, "REG_STATUS");
    report_test("reset state", err0);
  endtask

  task automatic run_entry(input int idx);
    entry_t e;
    int     err0;
    e         = table_q[idx];
    err0      = errors;
    cur_ctrl  = {30'd0, e.blur, e.pal};
    cur_vsize = size_word(e.vact, e.vtot);
    cur_hsize = size_word(e.hact, e.htot);
    write_expect(REG_CTRL, cur_ctrl, OKAY, "REG_CTRL write");
    write_expect(REG_VSIZE, cur_vsize, OKAY, "REG_VSIZE write");
    write_expect(REG_HSIZE, cur_hsize, OKAY, "REG_HSIZE write");
    wait_settled();
    v_exp = ref_axis(lines_full(e.pal), e.vact, e.vtot);
    h_exp = ref_axis(pixels_full(e.blur), e.hact, e.htot);
    check_outputs(v_exp, h_exp);
    read_expect(REG_CTRL, cur_ctrl, "REG_CTRL");
    read_expect(REG_VSIZE, cur_vsize, "REG_VSIZE");
    read_expect(REG_HSIZE, cur_hsize, "REG_HSIZE");
    read_expect(REG_VFACTOR, 32'(v_exp.factor), "REG_VFACTOR");
    read_expect(REG_HFACTOR, 32'(h_exp.factor), "REG_HFACTOR");
    report_test($sformatf("table entry %0d", idx), err0);
  endtask

  task automatic watch_idle(input int cycles, input string name);
    logic [SNAP_W-1:0] snap;
    int                c0;
    bit                changed;
    snap    = outputs_now();
    c0      = upd_cnt;
    changed = 1'b0;
    repeat (cycles) begin
      @(negedge SYS_CLK);
      if (outputs_now() !== snap) changed = 1'b1;
    end
    compare_value({name, " cfg_update_o pulses"}, upd_cnt - c0, 0);
    if (changed) begin
      $display("Error: result outputs changed although no update was due (%s)", name);
      errors++;
    end
  endtask

  task automatic check_coalesce();
    int err0;
    err0 = errors;
    write_expect(REG_VSIZE, size_word(100, 262), OKAY, "first REG_VSIZE write");
    cur_vsize = size_word(230, 262);
    write_expect(REG_VSIZE, cur_vsize, OKAY, "second REG_VSIZE write");
    wait_settled();
    v_exp = ref_axis(lines_full(cur_ctrl[0]), 230, 262);
    check_outputs(v_exp, h_exp);
    watch_idle(100, "after coalesced writes");
    report_test("back to back vsize writes", err0);
  endtask

  task automatic check_bad_access();
    logic [31:0] data;
    logic [1:0]  resp;
    int          err0;
    err0 = errors;
    write_expect(8'h40, 32'h0000_1234, SLVERR, "unmapped write");
    write_expect(REG_STATUS, 32'h0000_0001, SLVERR, "REG_STATUS write");
    write_expect(REG_VFACTOR, 32'h0000_0100, SLVERR, "REG_VFACTOR write");
    axi_read(8'h24, data, resp);
    compare_value("unmapped read rresp", resp, SLVERR);
    watch_idle(60, "after bad accesses");  // longer than one calculation
    check_outputs(v_exp, h_exp);
    read_expect(REG_CTRL, cur_ctrl, "REG_CTRL");
    report_test("slverr accesses", err0);
  endtask

  task automatic check_blur_only();
    int err0;
    err0 = errors;
    for (int k = 0; k < 2; k++) begin
      cur_ctrl[1] = ~cur_ctrl[1];  // only the horizontal resolution moves
      write_expect(REG_CTRL, cur_ctrl, OKAY, "REG_CTRL write");
      wait_settled();
      h_exp = ref_axis(pixels_full(cur_ctrl[1]), cur_hsize[SIZE_W-1:0],
                       cur_hsize[16 +: SIZE_W]);
      check_outputs(v_exp, h_exp);
    end
    report_test("nvideblur toggle", err0);
  endtask

  initial begin
    SYS_CLK     = 1'b0;
    arst_n_i    = 1'b0;
    s_awaddr_i  = '0;
    s_awvalid_i = 1'b0;
    s_wdata_i   = '0;
    s_wstrb_i   = '0;
    s_wvalid_i  = 1'b0;
    s_bready_i  = 1'b0;
    s_araddr_i  = '0;
    s_arvalid_i = 1'b0;
    s_rready_i  = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    v_exp        = '0;
    h_exp        = '0;
    // pal, blur, v active, v total, h active, h total
    table_q[0] = {1'b0, 1'b1, 12'd200, 12'd262, 12'd560, 12'd800};  // ntsc zoom
    table_q[1] = {1'b1, 1'b1, 12'd250, 12'd312, 12'd600, 12'd864};  // pal zoom
    table_q[2] = {1'b0, 1'b0, 12'd240, 12'd262, 12'd640, 12'd858};  // ntsc half h
    table_q[3] = {1'b1, 1'b0, 12'd300, 12'd280, 12'd720, 12'd640};  // upscale, clamped
    table_q[4] = {1'b0, 1'b1, 12'd480, 12'd400, 12'd900, 12'd800};
    repeat (10) @(negedge SYS_CLK);
    arst_n_i = 1'b1;
    @(negedge SYS_CLK);
    check_reset_state();
    for (int i = 0; i < N_ENTRY; i++) begin
      if (!timed_out) run_entry(i);
    end
    if (!timed_out) check_coalesce();
    if (!timed_out) check_bad_access();
    if (!timed_out) check_blur_only();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
verilog/scaler_pkg.sv
verilog/scaler_job_if.sv
verilog/scaler_result_if.sv
verilog/scaler_axil_regs.sv
verilog/serial_divide.sv
verilog/scaler_axis_calc.sv
verilog/scaler_cfg_commit.sv
verilog/scaler_cfg_top.sv
verification/scaler_cfg_tb.sv
